// ==== dv/tb_board_top.sv ====
module tb_board_top
    import stopwatch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    //------------------------------------------------------------
    // DUT set-up

    localparam clk_mhz      = 1;
    localparam tick_hz      = 100_000;
    localparam scan_hz      = 250_000;
    localparam w_key        = 4;
    localparam w_digit      = 4;
    localparam count_period = clk_mhz * 1_000_000 / tick_hz;  // Cycles per count step
    localparam count_mod    = 10_000;                          // Four decimal digits

    // Segment patterns, abcdefgh with a in bit 7
    localparam logic [7:0] seg_digits [0:9] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0, 8'hfe, 8'hf6
    };

    logic                 clk;
    logic [w_key   - 1:0] key_n;
    logic [          7:0] sw_n;
    wire  [          7:0] led_n;
    wire  [          7:0] abcdefgh_n;
    wire  [w_digit - 1:0] digit_n;
    wire                  in_reset = ~ key_n [w_key - 1];

    board_top
    # (
        .clk_mhz ( clk_mhz ),
        .tick_hz ( tick_hz ),
        .scan_hz ( scan_hz ),
        .w_key   ( w_key   ),
        .w_sw    ( 8       ),
        .w_led   ( 8       ),
        .w_digit ( w_digit )
    )
    UUT
    (
        .CLK        ( clk        ),
        .KEY_N      ( key_n      ),
        .SW_N       ( sw_n       ),
        .LED_N      ( led_n      ),
        .ABCDEFGH_N ( abcdefgh_n ),
        .DIGIT_N    ( digit_n    )
    );

    int           errors;
    int           errors_before;
    int           tests;
    int           tests_failed;
    int           cycle;
    logic [31:0]  rng;

    logic [15:0]        watch_last;          // LEDs and switches at the last falling edge
    logic [w_digit-1:0] fresh;               // Digits decoded since the display settled
    int                 holdoff;
    int                 shadow [0:w_digit - 1];
    logic [w_digit-1:0] shadow_blank;
    logic [7:0]         led_cur;
    logic [7:0]         led_last;
    logic [2:0]         run_hist;            // Running state over three samples

    initial begin
        clk = 1'b0;
        forever #4 clk = ~ clk;
    end

    always @ (posedge clk)
        cycle <= cycle + 1;

    //------------------------------------------------------------
    // Helpers

    function automatic logic [31:0] xorshift32 (input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_between (input int lo, input int hi);
        rng = xorshift32 (rng);
        return lo + int' (rng % (hi - lo + 1));
    endfunction

    function automatic int ticks_min (input int edges);
        return edges / count_period;
    endfunction

    function automatic int ticks_max (input int edges);
        return (edges + count_period - 1) / count_period;
    endfunction

    function automatic int seg_to_digit (input logic [7:0] segs);
        for (int i = 0; i < 10; i++)
            if (segs == seg_digits [i])
                return i;
        return -1;
    endfunction

    // Digit 9 shows as 001 and rolls over to 000
    function automatic logic low_bits_step_ok (input logic [2:0] prev, input logic [2:0] now);
        return (now == prev) || (now == prev + 3'd1) || (prev == 3'd1 && now == 3'd0);
    endfunction

    task automatic abort_run (input string reason);
        $display ("%s at %0t ns", reason, $time);
        $display ("tests %0d, failed %0d, errors %0d", tests, tests_failed + 1, errors);
        $display ("** FAIL **");
        $finish;
    endtask

    task automatic check_equal (input string name, input int got, input int expected);
        assert (got == expected)
        else begin
            $display ("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_range (input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi)
        else begin
            $display ("[ERROR] %0t ns %s: got %0d, expected %0d to %0d",
                      $time, name, got, lo, hi);
            errors++;
        end
    endtask

    task automatic finish_test (input string name);
        tests++;
        if (errors == errors_before) begin
            $display ("test %0d %s: ok", tests, name);
        end
        else begin
            tests_failed++;
            $display ("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    task automatic press_key (input key_index_e k, output int at);
        at = cycle;
        key_n [k] <= 1'b0;
        repeat (2) @ (posedge clk);
        key_n [k] <= 1'b1;
    endtask

    task automatic wait_state (input sw_state_t st);
        int n;
        n = 0;
        while (~ led_n [3:0] != (4'b0001 << st)) begin
            if (n == 40)
                abort_run ($sformatf ("Timeout while waiting for the %s state", st.name ()));
            @ (posedge clk);
            n++;
        end
    endtask

    task automatic read_display (output int value);
        int n;
        n = 0;
        repeat (2) @ (posedge clk);
        while (fresh != '1) begin
            if (n == 100)
                abort_run ("Timeout while waiting for a steady display");
            @ (posedge clk);
            n++;
        end
        value = 0;
        for (int i = w_digit - 1; i >= 0; i--)
            value = value * 10 + shadow [i];
    endtask

    //------------------------------------------------------------
    // Display monitor, builds a shadow of the scanned digits

    always @ (negedge clk) begin : display_monitor
        int   value;
        logic off;

        if (in_reset) begin
            fresh      <= '0;
            holdoff    <= 2;
            watch_last <= { led_n, sw_n };
            led_cur    <= 8'h01;
            led_last   <= 8'h01;
            run_hist   <= '0;
        end
        else begin
            led_last   <= led_cur;
            led_cur    <= ~ led_n;
            run_hist   <= { run_hist [1:0], ~ led_n [1] };
            watch_last <= { led_n, sw_n };

            if ({ led_n, sw_n } != watch_last) begin
                fresh   <= '0;  // Segments follow up to two cycles later
                holdoff <= 2;
            end
            else if (holdoff != 0) begin
                holdoff <= holdoff - 1;
            end
            else begin
                for (int i = 0; i < w_digit; i++) begin
                    if (! digit_n [i]) begin
                        off   = (~ abcdefgh_n == seg_blank);
                        value = seg_to_digit (~ abcdefgh_n);
                        assert (off || value >= 0)
                        else begin
                            $display ("[ERROR] %0t ns ABCDEFGH_N: got %h, expected a digit",
                                      $time, abcdefgh_n);
                            errors++;
                        end
                        shadow [i]       <= off ? 0 : value;
                        shadow_blank [i] <= off;
                        fresh [i]        <= 1'b1;
                    end
                end
            end
        end
    end

    //------------------------------------------------------------
    // Checks that hold all the time

    assert property (@ (posedge clk) disable iff (in_reset) $onehot (~ digit_n))
    else begin
        $display ("[ERROR] %0t ns DIGIT_N: got %b, expected one digit low",
                  $time, $sampled (digit_n));
        errors++;
    end

    assert property (@ (posedge clk) disable iff (in_reset) $onehot (~ led_n [3:0]))
    else begin
        $display ("[ERROR] %0t ns LED_N[3:0]: got %b, expected one state lit",
                  $time, $sampled (led_n [3:0]));
        errors++;
    end

    // Display held in lap
    assert property (@ (posedge clk) disable iff (in_reset)
        ! (led_last [3] && led_cur [3]) || (led_cur [7:5] == led_last [7:5]))
    else begin
        $display ("[ERROR] %0t ns LED_N[7:5] in lap: got %0d, expected %0d",
                  $time, led_cur [7:5], led_last [7:5]);
        errors++;
    end

    // Counting only moves forward
    assert property (@ (posedge clk) disable iff (in_reset)
        (run_hist != 3'b111) || low_bits_step_ok (led_last [7:5], led_cur [7:5]))
    else begin
        $display ("[ERROR] %0t ns LED_N[7:5] running: got %0d, expected %0d or one step on",
                  $time, led_cur [7:5], led_last [7:5]);
        errors++;
    end

    //------------------------------------------------------------
    // Stimulus

    initial begin : stimulus
        int t0;
        int t1;
        int t2;
        int t3;
        int base;
        int frozen;
        int shown;

        rng           = 32'h65d4119a;
        errors        = 0;
        errors_before = 0;
        tests         = 0;
        tests_failed  = 0;
        cycle         = 0;
        key_n         = '1;
        key_n [w_key - 1] = 1'b0;  // Reset key held
        sw_n          = '1;

        repeat (4) @ (posedge clk);
        key_n [w_key - 1] <= 1'b1;
        @ (posedge clk);

        // Reset state with and without blanking
        check_equal ("LED_N", 8' (~ led_n), 8'h01);
        read_display (shown);
        check_equal ("display", shown, 0);
        check_equal ("blanked digits", shadow_blank, 4'b0000);
        sw_n [0] <= 1'b0;
        @ (posedge clk);
        read_display (shown);
        check_equal ("display", shown, 0);
        check_equal ("blanked digits", shadow_blank, 4'b1110);  // Only digit 0 lit
        sw_n [0] <= 1'b1;
        @ (posedge clk);
        finish_test ("reset state");

        press_key (key_start_stop, t0);
        wait_state (running);
        repeat (rand_between (30, 300)) @ (posedge clk);
        press_key (key_start_stop, t1);
        wait_state (paused);
        read_display (shown);
        check_range ("display", shown, ticks_min (t1 - t0), ticks_max (t1 - t0));
        finish_test ("run and stop");

        base = shown;
        repeat (rand_between (20, 200)) @ (posedge clk);
        read_display (shown);
        check_equal ("paused display", shown, base);
        press_key (key_start_stop, t0);
        wait_state (running);
        repeat (rand_between (30, 300)) @ (posedge clk);
        press_key (key_start_stop, t1);
        wait_state (paused);
        read_display (shown);
        check_range ("resumed display", shown,
                     base + ticks_min (t1 - t0), base + ticks_max (t1 - t0));
        finish_test ("pause and resume");

        base = shown;
        press_key (key_start_stop, t0);
        wait_state (running);
        repeat (rand_between (20, 150)) @ (posedge clk);
        press_key (key_lap, t1);
        wait_state (lap);
        read_display (frozen);
        check_range ("frozen display", frozen,
                     base + ticks_min (t1 - t0 - 1), base + ticks_max (t1 - t0 - 1));
        repeat (rand_between (40, 200)) @ (posedge clk);
        read_display (shown);
        check_equal ("lap display", shown, frozen);
        press_key (key_lap, t2);
        wait_state (running);
        repeat (rand_between (20, 150)) @ (posedge clk);
        press_key (key_start_stop, t3);
        wait_state (paused);
        read_display (shown);
        check_range ("display gain after lap", shown - frozen,
                     ticks_min (t3 - t1 + 1), ticks_max (t3 - t1 + 1));
        check_range ("display after lap", shown,
                     base + ticks_min (t3 - t0), base + ticks_max (t3 - t0));
        finish_test ("lap");

        press_key (key_clear, t0);
        wait_state (idle);
        read_display (shown);
        check_equal ("cleared display", shown, 0);
        check_equal ("LED_N", 8' (~ led_n), 8'h01);
        press_key (key_start_stop, t0);
        wait_state (running);
        repeat (rand_between (20, 100)) @ (posedge clk);
        press_key (key_clear, t2);
        repeat (10) @ (posedge clk);
        check_equal ("LED_N[3:0]", 4' (~ led_n [3:0]), 4'b0010);  // Still running
        press_key (key_start_stop, t1);
        wait_state (paused);
        read_display (shown);
        check_range ("display", shown, ticks_min (t1 - t0), ticks_max (t1 - t0));
        press_key (key_clear, t0);
        wait_state (idle);
        finish_test ("clear");

        // Over ten thousand ticks
        press_key (key_start_stop, t0);
        wait_state (running);
        repeat (rand_between (100_100, 100_300)) @ (posedge clk);
        press_key (key_start_stop, t1);
        wait_state (paused);
        read_display (shown);
        check_range ("wrapped display", shown,
                     ticks_min (t1 - t0) % count_mod, ticks_max (t1 - t0) % count_mod);
        check_equal ("LED_N[4]", 1' (~ led_n [4]), 1);
        press_key (key_clear, t0);
        wait_state (idle);
        read_display (shown);
        check_equal ("cleared display", shown, 0);
        check_equal ("LED_N[4]", 1' (~ led_n [4]), 0);
        finish_test ("wrap");

        $display ("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0)
            $display ("** PASS **");
        else
            $display ("** FAIL **");
        $finish;
    end

endmodule

// ==== src.f ====
src/stopwatch_pkg.sv
src/stopwatch_if.sv
src/tick_timer.sv
src/stopwatch_fsm.sv
src/bcd_counter.sv
src/seven_seg_scan.sv
src/lab_top.sv
src/board_top.sv
dv/tb_board_top.sv

// ==== src/bcd_counter.sv ====
module bcd_counter
#(
    parameter w_digit = 4
)
(
    input                              clk,
    input                              reset,
    stopwatch_if.counter               ctl,
    output logic [4 * w_digit - 1:0]   display_digits
);

    //------------------------------------------------------------

    logic [w_digit - 1:0][3:0] count;
    logic [w_digit - 1:0][3:0] count_inc;
    logic                      roll_over;  // Every digit was nine

    //------------------------------------------------------------
    // Ripple carry through all digits in one cycle

    always_comb begin : next_count
        logic carry;

        carry = 1'b1;

        for (int i = 0; i < w_digit; i++) begin
            if (! carry) begin
                count_inc [i] = count [i];
            end
            else if (count [i] == 4'd9) begin
                count_inc [i] = 4'd0;  // Carry moves on
            end
            else begin
                count_inc [i] = count [i] + 4'd1;
                carry         = 1'b0;
            end
        end

        roll_over = carry;
    end

    //------------------------------------------------------------
    // Count register

    always_ff @ (posedge clk) begin
        if (reset) begin
            count       <= '0;
            ctl.wrapped <= 1'b0;
        end
        else begin
            ctl.wrapped <= 1'b0;

            if (ctl.clear) begin
                count <= '0;
            end
            else if (ctl.tick && ctl.run) begin
                count       <= count_inc;
                ctl.wrapped <= roll_over;  // 99..9 to 00..0
            end
        end
    end

    //------------------------------------------------------------
    // Display latch, held during lap

    always_ff @ (posedge clk) begin
        if (reset)
            display_digits <= '0;
        else if (! ctl.lap_freeze)
            display_digits <= count;
    end

endmodule

// ==== src/board_top.sv ====
module board_top
#(
    parameter clk_mhz = 50,
              tick_hz = 100,
              scan_hz = 1000,
              w_key   = 4,
              w_sw    = 8,
              w_led   = 8,
              w_digit = 4
)
(
    input                  CLK,

    input  [w_key   - 1:0] KEY_N,  // Top key is the reset
    input  [w_sw    - 1:0] SW_N,
    output [w_led   - 1:0] LED_N,

    output [          7:0] ABCDEFGH_N,
    output [w_digit - 1:0] DIGIT_N
);

    //------------------------------------------------------------

    localparam w_lab_key = w_key - 1;

    wire                   clk     = CLK;
    wire                   reset   = ~ KEY_N [w_key     - 1];
    wire [w_lab_key - 1:0] lab_key = ~ KEY_N [w_lab_key - 1:0];

    wire [w_led     - 1:0] led;
    wire [            7:0] abcdefgh;
    wire [w_digit   - 1:0] digit;

    //------------------------------------------------------------

    lab_top
    # (
        .clk_mhz  (   clk_mhz   ),
        .tick_hz  (   tick_hz   ),
        .scan_hz  (   scan_hz   ),
        .w_key    (   w_lab_key ),
        .w_sw     (   w_sw      ),
        .w_led    (   w_led     ),
        .w_digit  (   w_digit   )
    )
    i_lab_top
    (
        .clk      (   clk       ),
        .reset    (   reset     ),
        .key      (   lab_key   ),
        .sw       ( ~ SW_N      ),
        .led      (   led       ),
        .abcdefgh (   abcdefgh  ),
        .digit    (   digit     )
    );

    //------------------------------------------------------------
    // Active-low board outputs

    assign LED_N      = ~ led;
    assign ABCDEFGH_N = ~ abcdefgh;
    assign DIGIT_N    = ~ digit;

endmodule

// ==== src/lab_top.sv ====
module lab_top
    import stopwatch_pkg::*;
#(
    parameter clk_mhz = 50,
              tick_hz = 100,
              scan_hz = 1000,
              w_key   = 3,
              w_sw    = 8,
              w_led   = 8,
              w_digit = 4
)
(
    input                  clk,
    input                  reset,

    input  [w_key   - 1:0] key,
    input  [w_sw    - 1:0] sw,
    output [w_led   - 1:0] led,

    output [          7:0] abcdefgh,
    output [w_digit - 1:0] digit
);

    //------------------------------------------------------------
    // Strobe timers

    logic count_strobe;
    logic scan_strobe;

    tick_timer # (.clk_mhz (clk_mhz), .rate_hz (tick_hz))
    i_count_timer (.clk (clk), .reset (reset), .strobe (count_strobe));

    tick_timer # (.clk_mhz (clk_mhz), .rate_hz (scan_hz))
    i_scan_timer (.clk (clk), .reset (reset), .strobe (scan_strobe));

    //------------------------------------------------------------
    // Control and counting

    stopwatch_if # (.w_digit (w_digit)) sw_bus ();

    assign sw_bus.tick = count_strobe;

    sw_state_t                state;
    logic                     wrap_seen;
    logic [4 * w_digit - 1:0] display_digits;

    stopwatch_fsm # (.w_key (w_key))
    i_fsm
    (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .key       ( key       ),
        .state     ( state     ),
        .wrap_seen ( wrap_seen ),
        .ctl       ( sw_bus    )
    );

    bcd_counter # (.w_digit (w_digit))
    i_counter
    (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .ctl            ( sw_bus         ),
        .display_digits ( display_digits )
    );

    //------------------------------------------------------------
    // Display

    seven_seg_scan # (.w_digit (w_digit))
    i_scan
    (
        .clk         ( clk            ),
        .reset       ( reset          ),
        .scan_strobe ( scan_strobe    ),
        .blank_zeros ( sw [0]         ),  // Switch 0 blanks leading zeros
        .digits      ( display_digits ),
        .abcdefgh    ( abcdefgh       ),
        .digit       ( digit          )
    );

    //------------------------------------------------------------
    // LEDs

    logic [3:0] state_onehot;
    logic [8:0] led_wide;

    assign state_onehot = 4'b0001 << state;
    assign led_wide     = { display_digits [3:0], wrap_seen, state_onehot };
    assign led          = w_led' (led_wide);  // Upper LEDs show the lowest digit

endmodule

// ==== src/seven_seg_scan.sv ====
module seven_seg_scan
    import stopwatch_pkg::*;
#(
    parameter w_digit = 4
)
(
    input                            clk,
    input                            reset,
    input                            scan_strobe,
    input                            blank_zeros,
    input        [4 * w_digit - 1:0] digits,
    output logic [              7:0] abcdefgh,
    output       [w_digit     - 1:0] digit
);

    //------------------------------------------------------------
    // Segment table, abcdefgh order

    localparam logic [0:9][7:0] seg_table = {
        8'b1111_1100,  // 0
        8'b0110_0000,  // 1
        8'b1101_1010,  // 2
        8'b1111_0010,  // 3
        8'b0110_0110,  // 4
        8'b1011_0110,  // 5
        8'b1011_1110,  // 6
        8'b1110_0000,  // 7
        8'b1111_1110,  // 8
        8'b1111_0110   // 9
    };

    function automatic logic [7:0] seg_decode (input logic [3:0] bcd);
        if (bcd <= 4'd9)
            return seg_table [bcd];
        else
            return seg_blank;  // Not a BCD value
    endfunction

    //------------------------------------------------------------

    logic [w_digit - 1:0] sel;        // One-hot digit pointer
    logic [w_digit - 1:0] sel_next;
    logic [w_digit - 1:0] lead_zero;  // Zero with only zeros above
    logic [          3:0] bcd_sel;
    logic                 blank_sel;

    assign sel_next = scan_strobe ? (sel << 1) | (sel >> (w_digit - 1)) : sel;

    // Leading zero detection from the top digit down
    always_comb begin : leading_zeros
        logic all_zero;

        all_zero  = 1'b1;
        lead_zero = '0;

        for (int i = w_digit - 1; i > 0; i--) begin
            all_zero      = all_zero && (digits [4 * i +: 4] == 4'd0);
            lead_zero [i] = all_zero;
        end
    end

    always_comb begin
        bcd_sel   = 4'd0;
        blank_sel = 1'b0;

        for (int i = 0; i < w_digit; i++) begin
            if (sel_next [i]) begin
                bcd_sel   = digits [4 * i +: 4];
                blank_sel = blank_zeros && lead_zero [i];
            end
        end
    end

    //------------------------------------------------------------
    // Pointer and segments change on the same edge

    always_ff @ (posedge clk) begin
        if (reset) begin
            sel      <= w_digit' (1);  // Digit 0
            abcdefgh <= seg_table [0];
        end
        else begin
            sel      <= sel_next;
            abcdefgh <= blank_sel ? seg_blank : seg_decode (bcd_sel);
        end
    end

    assign digit = sel;

endmodule

// ==== src/stopwatch_fsm.sv ====
module stopwatch_fsm
    import stopwatch_pkg::*;
#(
    parameter w_key = 3
)
(
    input                      clk,
    input                      reset,
    input        [w_key - 1:0] key,
    output sw_state_t          state,
    output logic               wrap_seen,
    stopwatch_if.fsm           ctl
);

    //------------------------------------------------------------
    // Key synchronizer and press detector

    logic [w_key - 1:0] key_meta;
    logic [w_key - 1:0] key_sync;
    logic [w_key - 1:0] key_prev;
    logic [w_key - 1:0] press;

    always_ff @ (posedge clk) begin
        if (reset) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end
        else begin
            key_meta <= key;       // First flop
            key_sync <= key_meta;  // Second flop
            key_prev <= key_sync;
        end
    end

    assign press = key_sync & ~ key_prev;  // Rising edge only

    //------------------------------------------------------------
    // State machine

    sw_state_t state_next;
    logic      clear_go;
    logic      paused_from_lap;  // Display stays frozen in paused
    logic      clear_pulse;

    always_comb begin
        state_next = state;

        case (state)
            idle:
                if (press [key_start_stop])
                    state_next = running;
            running:
                if (press [key_start_stop])
                    state_next = paused;
                else if (press [key_lap])
                    state_next = lap;
            lap:
                if (press [key_start_stop])
                    state_next = paused;
                else if (press [key_lap])
                    state_next = running;
            paused:
                if (press [key_start_stop])
                    state_next = running;
                else if (press [key_clear])
                    state_next = idle;
            default:
                state_next = idle;
        endcase
    end

    assign clear_go = (state == paused) && (state_next == idle);

    always_ff @ (posedge clk) begin
        if (reset) begin
            state           <= idle;
            paused_from_lap <= 1'b0;
            clear_pulse     <= 1'b0;
            wrap_seen       <= 1'b0;
        end
        else begin
            state       <= state_next;
            clear_pulse <= clear_go;  // One cycle wide

            if (state == lap && state_next == paused)
                paused_from_lap <= 1'b1;
            else if (state_next != paused)
                paused_from_lap <= 1'b0;

            if (clear_go)
                wrap_seen <= 1'b0;
            else if (ctl.wrapped)
                wrap_seen <= 1'b1;  // Sticky until clear
        end
    end

    //------------------------------------------------------------

    assign ctl.run        = (state == running) || (state == lap);
    assign ctl.lap_freeze = (state == lap) || (state == paused && paused_from_lap);
    assign ctl.clear      = clear_pulse;

endmodule

// ==== src/stopwatch_if.sv ====
interface stopwatch_if
#(
    parameter w_digit = 4  // Digits of the attached counter
);

    logic run;         // Counter may advance
    logic clear;       // One-cycle clear request
    logic lap_freeze;  // Hold the display register
    logic tick;        // Count timer strobe
    logic wrapped;     // Count rolled over from all nines

    modport fsm
    (
        output run,
        output clear,
        output lap_freeze,
        input  wrapped
    );

    modport counter
    (
        input  run,
        input  clear,
        input  lap_freeze,
        input  tick,
        output wrapped
    );

endinterface

// ==== src/stopwatch_pkg.sv ====
package stopwatch_pkg;

    //------------------------------------------------------------
    // Stopwatch states

    localparam w_state = 2;

    typedef enum logic [w_state - 1:0] {
        idle    = 2'd0,  // Count cleared and stopped
        running = 2'd1,
        paused  = 2'd2,
        lap     = 2'd3   // Counting with the display held
    } sw_state_t;

    //------------------------------------------------------------
    // Lab key positions

    typedef enum logic [1:0] {
        key_start_stop = 2'd0,
        key_lap        = 2'd1,
        key_clear      = 2'd2
    } key_index_e;

    //------------------------------------------------------------
    // Seven-segment encoding
    // Bit 7 is segment a and bit 0 is the decimal point h

    localparam logic [7:0] seg_blank = 8'b0000_0000;  // All segments off

endpackage

// ==== src/tick_timer.sv ====
module tick_timer
#(
    parameter clk_mhz = 50,
              rate_hz = 100
)
(
    input        clk,
    input        reset,
    output logic strobe
);

    //------------------------------------------------------------

    localparam period = clk_mhz * 1_000_000 / rate_hz;  // Clock cycles per strobe
    localparam w_cnt  = $clog2 (period + 1);

    logic [w_cnt - 1:0] cnt;

    //------------------------------------------------------------
    // Down-counter with reload at terminal count

    always_ff @ (posedge clk) begin
        if (reset) begin
            cnt    <= w_cnt' (period - 1);
            strobe <= 1'b0;
        end
        else if (cnt == '0) begin
            cnt    <= w_cnt' (period - 1);  // Reload
            strobe <= 1'b1;
        end
        else begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

endmodule
